// File: project.f
+incdir+tb
design/tpu_pkg.sv
design/fifo_if.sv
design/activation_unit.sv
design/command_decoder.sv
design/cmd_queue.sv
design/buffer_engine.sv
design/result_sender.sv
design/tpu_top.sv
tb/tb_tpu_top.sv

// File: Bender.yml
package:
  name: tpu_accel

sources:
  - design/tpu_pkg.sv
  - design/fifo_if.sv
  - design/activation_unit.sv
  - design/command_decoder.sv
  - design/cmd_queue.sv
  - design/buffer_engine.sv
  - design/result_sender.sv
  - design/tpu_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_tpu_top.sv

// File: tb/tb_vectors.svh
`ifndef tb_vectors_svh
`define tb_vectors_svh

// each row has a name, the bytes sent to the DUT and the bytes expected back
// bytes are two hex digits separated by single spaces
// instruction low byte is relu_en[4] quant_en[3] opcode[2:0]
// instruction high byte is source or store address[7:4], run destination[3:0]
// a store is followed by its value, low byte first

task automatic load_table();
	// three addresses written and read back
	add_row("store_fetch_alias",
		"00 10 34 12 00 20 cd ab 00 f0 01 80 01 10 01 20 01 f0",
		"34 12 cd ab 01 80");
	// plain copy from word 3 to word 4
	add_row("run_copy",
		"00 30 5a 5a 02 34 01 40",
		"5a 5a");
	// 0x0100 shifts to 16 and saturates to 7
	add_row("quant_pos_sat",
		"00 50 00 01 0a 56 01 60",
		"07 00");
	// 0xff00 shifts to -16 and saturates to -8
	add_row("quant_neg_sat",
		"00 50 00 ff 0a 56 01 60",
		"f8 ff");
	// 53 gives 3, -48 gives -3
	add_row("quant_in_range",
		"00 50 35 00 0a 56 00 70 d0 ff 0a 78 01 60 01 80",
		"03 00 fd ff");
	// -8 after the quantizer becomes -2, positive 5 is kept
	add_row("quant_relu",
		"00 90 00 ff 1a 9a 00 b0 50 00 1a bc 01 a0 01 c0",
		"fe ff 05 00");
	// -100 becomes -25, 0x0123 passes unchanged
	add_row("relu_only",
		"00 d0 9c ff 12 de 01 e0 00 d0 23 01 12 de 01 e0",
		"e7 ff 23 01");
	// nop and opcodes 3, 4, 6, 7 are silent, the fetch after them still works
	add_row("nop_unused",
		"05 00 03 00 04 00 06 00 07 00 01 10",
		"34 12");
	// six fetches in a row, more bytes than the output queue holds
	add_row("back_pressure",
		"01 10 01 20 01 f0 01 30 01 80 01 a0",
		"34 12 cd ab 01 80 5a 5a fd ff fe ff");
endtask

`endif

// File: tb/tb_tpu_top.sv
module tb_tpu_top import tpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period   = 40;
	localparam int reset_cycles = 4;
	// watchdog budget per input byte
	localparam int cycles_per_byte = 60;
	// quiet time after the last expected byte so a stray byte still gets seen
	localparam int drain_cycles = 100;

	logic              clk = 1'b0;
	logic              rst_int;
	logic              in_req;
	logic [byte_w-1:0] in_data;
	logic              in_ack;
	logic              out_req;
	logic [byte_w-1:0] out_data;
	logic              out_ack;

	logic [31:0] lfsr = 32'he092;
	int          errors = 0;
	int          rx_count = 0;
	bit          table_loaded = 1'b0;

	// table rows, byte streams kept flat
	string             row_name [$];
	int                row_first [$];
	int                row_count [$];
	logic [byte_w-1:0] in_bytes [$];
	logic [byte_w-1:0] exp_bytes [$];
	int                exp_row [$];

	tpu_top UUT (
		.clk      (clk),
		.rst_int  (rst_int),
		.in_req   (in_req),
		.in_data  (in_data),
		.in_ack   (in_ack),
		.out_req  (out_req),
		.out_data (out_data),
		.out_ack  (out_ack)
	);

	always #(clk_period / 2) clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, one new bit per call
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	task automatic add_row(input string name, input string stim, input string expected);
		int row;
		row = row_name.size();
		row_name.push_back(name);
		row_first.push_back(in_bytes.size());
		row_count.push_back((stim.len() + 1) / 3);
		for (int k = 0; k < (stim.len() + 1) / 3; k++)
			in_bytes.push_back(byte_w'(stim.substr(3 * k, 3 * k + 1).atohex()));
		for (int k = 0; k < (expected.len() + 1) / 3; k++) begin
			exp_bytes.push_back(byte_w'(expected.substr(3 * k, 3 * k + 1).atohex()));
			exp_row.push_back(row);
		end
	endtask

	`include "tb_vectors.svh"

	task automatic check_value(input string name, input logic [31:0] expected,
				   input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error: %s expected 0x%0h actual 0x%0h at %0t",
				 name, expected, actual, $time);
		end
	endtask

	// host side of the input link, data held until ack has dropped again
	task automatic send_byte(input logic [byte_w-1:0] b);
		in_data <= b;
		in_req  <= 1'b1;
		do
			@(posedge clk);
		while (!in_ack);
		in_req <= 1'b0;
		do
			@(posedge clk);
		while (in_ack);
	endtask

	task automatic record_byte(input logic [byte_w-1:0] b);
		if (rx_count < exp_bytes.size()) begin
			check_value($sformatf("%s byte %0d", row_name[exp_row[rx_count]], rx_count),
				    exp_bytes[rx_count], b);
		end else begin
			errors++;
			$display("unexpected output byte 0x%0h after the expected stream", b);
		end
		rx_count++;
	endtask

	// output link host with a random ack delay of 0 to 3 cycles
	initial begin : output_host
		int ack_delay;
		forever begin
			@(posedge clk);
			if (out_req === 1'b1) begin
				record_byte(out_data);
				ack_delay = random_bits(2);
				repeat (ack_delay) @(posedge clk);
				out_ack <= 1'b1;
				do
					@(posedge clk);
				while (out_req);
				out_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (table_loaded);
		repeat (in_bytes.size() * cycles_per_byte) @(posedge clk);
		$display("timeout: the output stream did not complete in %0d cycles",
			 in_bytes.size() * cycles_per_byte);
		$display("errors %0d, bytes received %0d of %0d", errors, rx_count, exp_bytes.size());
		$display("test failed");
		$finish;
	end

	initial begin
		rst_int <= 1'b1;
		in_req  <= 1'b0;
		in_data <= '0;
		out_ack <= 1'b0;
		load_table();
		table_loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst_int <= 1'b0;
		for (int r = 0; r < row_name.size(); r++) begin
			for (int i = 0; i < row_count[r]; i++)
				send_byte(in_bytes[row_first[r] + i]);
		end
		while (rx_count < exp_bytes.size())
			@(posedge clk);
		repeat (drain_cycles) @(posedge clk);
		check_value("received byte count", exp_bytes.size(), rx_count);
		$display("errors %0d, bytes received %0d of %0d", errors, rx_count, exp_bytes.size());
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: design/tpu_top.sv
module tpu_top import tpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_int,
	input  logic              in_req,
	input  logic [byte_w-1:0] in_data,
	output logic              in_ack,
	output logic              out_req,
	output logic [byte_w-1:0] out_data,
	input  logic              out_ack
);

	fifo_if #(.payload_t(cmd_t)) cmd_q ();
	fifo_if #(.payload_t(logic [byte_w-1:0])) out_q ();

	command_decoder u_decoder (
		.clk     (clk),
		.rst_int (rst_int),
		.in_req  (in_req),
		.in_data (in_data),
		.in_ack  (in_ack),
		.cmd     (cmd_q.writer)
	);

	cmd_queue #(.payload_t(cmd_t), .depth(cmd_depth)) u_cmd_queue (
		.clk     (clk),
		.rst_int (rst_int),
		.q       (cmd_q.queue)
	);

	buffer_engine u_engine (
		.clk     (clk),
		.rst_int (rst_int),
		.cmd     (cmd_q.reader),
		.out     (out_q.writer)
	);

	cmd_queue #(.payload_t(logic [byte_w-1:0]), .depth(out_depth)) u_out_queue (
		.clk     (clk),
		.rst_int (rst_int),
		.q       (out_q.queue)
	);

	result_sender u_sender (
		.clk      (clk),
		.rst_int  (rst_int),
		.out      (out_q.reader),
		.out_req  (out_req),
		.out_data (out_data),
		.out_ack  (out_ack)
	);

endmodule

// File: design/result_sender.sv
module result_sender import tpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_int,
	fifo_if.reader            out,
	output logic              out_req,
	output logic [byte_w-1:0] out_data,
	input  logic              out_ack
);

	typedef enum logic [1:0] {
		st_pop,
		st_request,
		st_release
	} state_e;

	state_e state;

	assign out.rd_en = (state == st_pop) && !out.empty;

	always_ff @(posedge clk) begin
		if (rst_int) begin
			state   <= st_pop;
			out_req <= 1'b0;
		end else begin
			case (state)
				st_pop: if (out.rd_en) state <= st_request;
				st_request: begin
					// first cycle here has the popped byte on rd_data
					if (!out_req) begin
						out_req <= 1'b1;
					end else if (out_ack) begin
						out_req <= 1'b0;
						state   <= st_release;
					end
				end
				// host must drop ack before the next byte goes out
				st_release: if (!out_ack) state <= st_pop;
				default:    state <= st_pop;
			endcase
		end
	end

	// queue holds rd_data until the next pop
	always_ff @(posedge clk) begin
		if (state == st_request) begin
			out_data <= out.rd_data;
		end
	end

	assert property (@(posedge clk) disable iff (rst_int) out_req |=> !out_req || $stable(out_data))
		else $error("out_data changed while out_req was high");

endmodule

// File: design/buffer_engine.sv
module buffer_engine import tpu_pkg::*; (
	input  logic   clk,
	input  logic   rst_int,
	fifo_if.reader cmd,
	fifo_if.writer out
);

	typedef enum logic [2:0] {
		st_idle,
		st_decode,
		st_run,
		st_fetch_lo,
		st_fetch_hi
	} state_e;

	state_e            state;
	cmd_t              cur;
	logic [word_w-1:0] mem [buf_depth];
	logic [word_w-1:0] rd_word;
	logic [word_w-1:0] act_out;
	logic              mem_we;
	logic [addr_w-1:0] mem_waddr;
	logic [word_w-1:0] mem_wdata;

	activation_unit u_activation (
		.word_in  (rd_word),
		.quant_en (cur.quant_en),
		.relu_en  (cur.relu_en),
		.word_out (act_out)
	);

	// pop only from idle, so one command is in flight at a time
	assign cmd.rd_en = (state == st_idle) && !cmd.empty;

	// fetched word leaves low byte first
	assign out.wr_en   = ((state == st_fetch_lo) || (state == st_fetch_hi)) && !out.full;
	assign out.wr_data = (state == st_fetch_hi) ? rd_word[word_w-1 -: byte_w] : rd_word[byte_w-1:0];

	// store writes straight from the popped command, run writes its result
	always_comb begin
		mem_we    = 1'b0;
		mem_waddr = cmd.rd_data.addr;
		mem_wdata = cmd.rd_data.value;
		if (state == st_decode && cmd.rd_data.op == op_store) begin
			mem_we = 1'b1;
		end else if (state == st_run) begin
			mem_we    = 1'b1;
			mem_waddr = cur.dest;
			mem_wdata = act_out;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[mem_waddr] <= mem_wdata;
		end
		if (state == st_decode) begin
			rd_word <= mem[cmd.rd_data.addr];
			cur     <= cmd.rd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_int) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (cmd.rd_en) state <= st_decode;
				st_decode: begin
					case (cmd.rd_data.op)
						op_run:   state <= st_run;
						op_fetch: state <= st_fetch_lo;
						// store is done in this cycle, nop is dropped
						op_store: state <= st_idle;
						op_nop:   state <= st_idle;
						default:  state <= st_idle;
					endcase
				end
				st_run:      state <= st_idle;
				st_fetch_lo: if (out.wr_en) state <= st_fetch_hi;
				st_fetch_hi: if (out.wr_en) state <= st_idle;
				default:     state <= st_idle;
			endcase
		end
	end

endmodule

// File: design/cmd_queue.sv
module cmd_queue #(
	parameter type payload_t = logic,
	parameter int  depth     = 2
) (
	input  logic  clk,
	input  logic  rst_int,
	fifo_if.queue q
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t         mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	assign q.full  = (count == cnt_w'(depth));
	assign q.empty = (count == '0);

	always_ff @(posedge clk) begin
		if (rst_int) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (q.wr_en) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (q.rd_en) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves when exactly one side is active
			case ({q.wr_en, q.rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (q.wr_en) begin
			mem[wr_ptr] <= q.wr_data;
		end
		if (q.rd_en) begin
			q.rd_data <= mem[rd_ptr];
		end
	end

	assert property (@(posedge clk) disable iff (rst_int) q.wr_en |-> !q.full)
		else $error("write into a full queue");

	assert property (@(posedge clk) disable iff (rst_int) q.rd_en |-> !q.empty)
		else $error("read from an empty queue");

endmodule

// File: design/command_decoder.sv
module command_decoder import tpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_int,
	input  logic              in_req,
	input  logic [byte_w-1:0] in_data,
	output logic              in_ack,
	fifo_if.writer            cmd
);

	typedef enum logic [1:0] {
		ph_instr_lo,
		ph_instr_hi,
		ph_value_lo,
		ph_value_hi
	} phase_e;

	phase_e            phase;
	logic [byte_w-1:0] instr_lo;
	logic [byte_w-1:0] value_lo;
	logic [word_w-1:0] instr_word;
	logic [word_w-1:0] cur_instr;
	opcode_e           cur_op;
	logic              completes;
	logic              take;

	function automatic cmd_t make_cmd(input logic [word_w-1:0] instr,
					  input logic [word_w-1:0] value);
		cmd_t c;
		c.op       = opcode_e'(instr[opcode_w-1:0]);
		c.addr     = instr[word_w-1 -: addr_w];
		c.dest     = instr[dest_lsb +: addr_w];
		c.quant_en = instr[quant_bit];
		c.relu_en  = instr[relu_bit];
		c.value    = value;
		return c;
	endfunction

	// little-endian, the high byte is the one on the link now
	assign cur_instr = {in_data, instr_lo};
	assign cur_op    = opcode_e'(cur_instr[opcode_w-1:0]);

	// a store is only complete after its two value bytes
	always_comb begin
		case (phase)
			ph_instr_hi: completes = (cur_op != op_store);
			ph_value_hi: completes = 1'b1;
			default:     completes = 1'b0;
		endcase
	end

	// hold off ack while the finished command has nowhere to go
	assign take = in_req && !in_ack && !(completes && cmd.full);

	always_ff @(posedge clk) begin
		if (rst_int) begin
			phase     <= ph_instr_lo;
			in_ack    <= 1'b0;
			cmd.wr_en <= 1'b0;
		end else begin
			cmd.wr_en <= 1'b0;
			if (take) begin
				in_ack    <= 1'b1;
				cmd.wr_en <= completes;
				case (phase)
					ph_instr_lo: phase <= ph_instr_hi;
					ph_instr_hi: phase <= (cur_op == op_store) ? ph_value_lo : ph_instr_lo;
					ph_value_lo: phase <= ph_value_hi;
					default:     phase <= ph_instr_lo;
				endcase
			end else if (in_ack && !in_req) begin
				in_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (phase)
				ph_instr_lo: instr_lo <= in_data;
				ph_instr_hi: begin
					instr_word  <= cur_instr;
					cmd.wr_data <= make_cmd(cur_instr, '0);
				end
				ph_value_lo: value_lo <= in_data;
				default:     cmd.wr_data <= make_cmd(instr_word, {in_data, value_lo});
			endcase
		end
	end

	// host keeps req up until it sees ack, so ack can only rise under req
	assert property (@(posedge clk) disable iff (rst_int) $rose(in_ack) |-> in_req)
		else $error("in_ack rose while in_req was low");

endmodule

// File: design/activation_unit.sv
module activation_unit import tpu_pkg::*; (
	input  logic [word_w-1:0] word_in,
	input  logic              quant_en,
	input  logic              relu_en,
	output logic [word_w-1:0] word_out
);

	logic signed [word_w-1:0] shifted;
	logic signed [word_w-1:0] quant;
	logic signed [word_w-1:0] stage;

	always_comb begin
		shifted = $signed(word_in) >>> quant_shift;

		// saturate to the signed 4-bit range, kept sign extended
		if (shifted > quant_max)
			quant = word_w'(quant_max);
		else if (shifted < quant_min)
			quant = word_w'(quant_min);
		else
			quant = shifted;

		stage = quant_en ? quant : $signed(word_in);

		// leaky relu scales only the negative side
		if (relu_en && stage < 0)
			word_out = stage >>> relu_shift;
		else
			word_out = stage;
	end

endmodule

// File: design/fifo_if.sv
interface fifo_if #(
	parameter type payload_t = logic
);

	// write side
	logic     wr_en;
	logic     full;
	payload_t wr_data;

	// read side, rd_data follows rd_en by one cycle
	logic     rd_en;
	logic     empty;
	payload_t rd_data;

	modport writer (output wr_en, output wr_data, input full);

	modport reader (output rd_en, input empty, input rd_data);

	modport queue (
		input  wr_en,
		input  wr_data,
		input  rd_en,
		output full,
		output empty,
		output rd_data
	);

endinterface

// File: design/tpu_pkg.sv
package tpu_pkg;

	// datapath widths
	localparam int word_w   = 16;
	localparam int byte_w   = 8;
	localparam int addr_w   = 4;
	localparam int opcode_w = 3;

	// word buffer size, one entry per address
	localparam int buf_depth = 16;

	// queue depths
	localparam int cmd_depth = 4;
	localparam int out_depth = 4;

	// instruction field positions
	// opcode sits in the low bits, source address in the top nibble
	localparam int dest_lsb  = 8;
	localparam int quant_bit = 3;
	localparam int relu_bit  = 4;

	// quantizer, signed 4-bit result after the shift
	localparam int quant_shift = 4;
	localparam int quant_min   = -8;
	localparam int quant_max   = 7;

	// leaky relu alpha as an arithmetic shift of negative values
	localparam int relu_shift = 2;

	typedef enum logic [opcode_w-1:0] {
		op_store = 3'd0,
		op_fetch = 3'd1,
		op_run   = 3'd2,
		op_nop   = 3'd5
	} opcode_e;

	// one decoded command as it travels through the command queue
	typedef struct packed {
		opcode_e           op;
		// source for run/fetch, target for store
		logic [addr_w-1:0] addr;
		// run destination
		logic [addr_w-1:0] dest;
		logic              quant_en;
		logic              relu_en;
		// store data, zero for other opcodes
		logic [word_w-1:0] value;
	} cmd_t;

endpackage
